//--- list.f
verilog/cache_pkg.sv
verilog/cache_ifs.sv
verilog/access_align.sv
verilog/beat_counter.sv
verilog/tag_store.sv
verilog/data_store.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
tests/mem_model.sv
tests/tb_dcache.sv

//--- run.sh
#!/bin/sh
# builds the dcache testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f list.f --top-module tb_dcache -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_dcache
status=$?
if [ $status -ne 0 ]; then
    echo "simulation returned status $status"
fi
exit $status

//--- tests/mem_model.sv
`timescale 1ns/100ps

module mem_model
    import cache_pkg::*;
#(
    parameter int BEATS = 4,
    parameter int WORDS = 4096
)(
    input  logic              clk,
    input  logic              rstn,
    input  logic              i_valid,
    output logic              o_ready,
    input  logic              i_write,
    input  logic [ADDR_W-1:0] i_addr,
    output logic              o_rvalid,
    output logic [DATA_W-1:0] o_rdata,
    input  logic              i_wvalid,
    output logic              o_wready,
    input  logic [DATA_W-1:0] i_wdata
);
    localparam int WA_W   = $clog2(WORDS);
    localparam int BEAT_W = $clog2(BEATS);

    typedef enum logic [1:0] {M_IDLE, M_READ, M_WRITE} mode_t;

    logic [DATA_W-1:0]      mem [WORDS];   // checked directly by the testbench
    mode_t                  mode;
    logic [WA_W-BEAT_W-1:0] line;
    logic [BEAT_W-1:0]      beat;
    logic                   stall;         // wait state on every other cycle

    assign o_ready  = (mode == M_IDLE) && !stall;
    assign o_wready = (mode == M_WRITE) && !stall;

    // every word gets a value spread over all of its address bits
    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = (i * 32'h0101_0107) ^ 32'h5a3c_96e1;
        end
    end

    always @(posedge clk) begin
        if (!rstn) begin
            mode     <= M_IDLE;
            beat     <= '0;
            stall    <= 1'b0;
            o_rvalid <= 1'b0;
            o_rdata  <= '0;
        end else begin
            o_rvalid <= 1'b0;
            stall    <= ~stall;
            case (mode)
                M_IDLE: begin
                    if (i_valid && o_ready) begin
                        line <= i_addr[WA_W+1:BEAT_W+2];
                        beat <= '0;
                        mode <= i_write ? M_WRITE : M_READ;
                    end
                end
                M_READ: begin   // one beat per cycle, no back-pressure
                    o_rvalid <= 1'b1;
                    o_rdata  <= mem[{line, beat}];
                    beat     <= beat + 1'b1;
                    if (&beat) mode <= M_IDLE;
                end
                default: begin
                    if (i_wvalid && o_wready) begin
                        mem[{line, beat}] <= i_wdata;
                        beat              <= beat + 1'b1;
                        if (&beat) mode <= M_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

//--- tests/tb_dcache.sv
`timescale 1ns/100ps

module tb_dcache
    import cache_pkg::*;
;
    localparam int INDEX_WIDTH       = 4;
    localparam int WORD_OFFSET_WIDTH = 2;
    localparam int BEATS             = 1 << WORD_OFFSET_WIDTH;
    localparam int MEM_WORDS         = 4096;
    localparam int RESET_CYCLES      = 5;
    localparam int NUM_RANDOM        = 40;
    localparam int MAX_ACCESSES      = 40 + NUM_RANDOM;   // directed part stays below 40
    localparam int WORST_CYCLES      = 40;                // write-back, refill, replay, hold
    localparam int CYCLE_LIMIT       = RESET_CYCLES + MAX_ACCESSES * WORST_CYCLES + 200;

    logic              clk = 1'b0;
    logic              rstn;
    logic              i_req_valid;
    logic              o_req_ready;
    logic              i_req_write;
    logic [ADDR_W-1:0] i_req_addr;
    size_t             i_req_size;
    logic              i_req_signed;
    logic [DATA_W-1:0] i_req_wdata;
    logic              o_resp_valid;
    logic              i_resp_ready;
    logic [DATA_W-1:0] o_resp_rdata;
    logic              o_resp_ale;
    logic              o_mem_valid;
    logic              i_mem_ready;
    logic              o_mem_write;
    logic [ADDR_W-1:0] o_mem_addr;
    logic              i_mem_rvalid;
    logic [DATA_W-1:0] i_mem_rdata;
    logic              o_mem_wvalid;
    logic              i_mem_wready;
    logic [DATA_W-1:0] o_mem_wdata;

    logic [7:0]        sb [4*MEM_WORDS];   // byte mirror of main memory
    logic              accept;
    logic              in_flight = 1'b0;
    logic              exp_hit   = 1'b0;
    logic              exp_ale   = 1'b0;
    logic              exp_load  = 1'b0;
    logic [DATA_W-1:0] exp_rdata = '0;
    int                seed;
    int                cycles = 0;

    always #20 clk = ~clk;

    dcache_top #(
        .INDEX_WIDTH       (INDEX_WIDTH),
        .WORD_OFFSET_WIDTH (WORD_OFFSET_WIDTH)
    ) u_dcache_top (.*);

    mem_model #(.BEATS(BEATS), .WORDS(MEM_WORDS)) u_mem (
        .clk      (clk),
        .rstn     (rstn),
        .i_valid  (o_mem_valid),
        .o_ready  (i_mem_ready),
        .i_write  (o_mem_write),
        .i_addr   (o_mem_addr),
        .o_rvalid (i_mem_rvalid),
        .o_rdata  (i_mem_rdata),
        .i_wvalid (o_mem_wvalid),
        .o_wready (i_mem_wready),
        .i_wdata  (o_mem_wdata)
    );

    assign accept = i_req_valid && o_req_ready;

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    assert property (@(posedge clk) $rose(rstn)
        |-> o_req_ready && !o_resp_valid && !o_mem_valid && !o_mem_wvalid)
        else fail_now("outputs not idle after reset");
    // a hit answers, a miss goes to memory, both two cycles after accept
    assert property (@(posedge clk) disable iff (!rstn) accept |-> ##2 (o_resp_valid ^ o_mem_valid))
        else fail_now("neither a response nor a memory request two cycles after accept");
    assert property (@(posedge clk) disable iff (!rstn) accept && exp_hit |-> ##2 o_resp_valid)
        else fail_now("expected hit did not respond two cycles after accept");
    assert property (@(posedge clk) disable iff (!rstn)
        accept && exp_ale |-> ##2 (o_resp_valid && o_resp_ale))
        else fail_now("misaligned request not flagged two cycles after accept");
    assert property (@(posedge clk) disable iff (!rstn) in_flight && exp_ale |-> !o_mem_valid)
        else fail_now("misaligned request started a memory transfer");
    assert property (@(posedge clk) disable iff (!rstn)
        o_resp_valid && i_resp_ready |-> o_resp_ale == exp_ale)
        else fail_now($sformatf("** Error: o_resp_ale = %h, expected %h",
                                $sampled(o_resp_ale), $sampled(exp_ale)));
    assert property (@(posedge clk) disable iff (!rstn)
        o_resp_valid && i_resp_ready && exp_load |-> o_resp_rdata == exp_rdata)
        else fail_now($sformatf("** Error: o_resp_rdata = %h, expected %h",
                                $sampled(o_resp_rdata), $sampled(exp_rdata)));
    assert property (@(posedge clk) disable iff (!rstn) o_resp_valid && !i_resp_ready
        |=> o_resp_valid && $stable(o_resp_rdata) && $stable(o_resp_ale) && !o_req_ready)
        else fail_now("response changed or dropped while stalled");

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) fail_now("timeout: the run exceeded its cycle limit");
    end

    function automatic logic [DATA_W-1:0] load_value(input logic [ADDR_W-1:0] a,
                                                     input size_t sz, input logic sgn);
        logic [DATA_W-1:0] w;
        w = {sb[a+3], sb[a+2], sb[a+1], sb[a]};   // little endian from the addressed byte
        case (sz)
            SZ_BYTE: return {{24{sgn & w[7]}}, w[7:0]};
            SZ_HALF: return {{16{sgn & w[15]}}, w[15:0]};
            default: return w;
        endcase
    endfunction

    task automatic store_bytes(input logic [ADDR_W-1:0] a, input size_t sz,
                               input logic [DATA_W-1:0] wd);
        int n;
        n = (sz == SZ_BYTE) ? 1 : (sz == SZ_HALF) ? 2 : 4;
        for (int k = 0; k < n; k++) begin
            sb[a+k] = wd[8*k +: 8];
        end
    endtask

    task automatic access(input logic wr, input logic [ADDR_W-1:0] addr, input size_t sz,
                          input logic sgn, input logic [DATA_W-1:0] wd,
                          input logic hit, input int hold);
        logic ale;
        ale = (sz == SZ_HALF && addr[0]) || (sz == SZ_WORD && addr[1:0] != 2'b00);
        @(posedge clk);
        i_req_valid  <= 1'b1;
        i_req_write  <= wr;
        i_req_addr   <= addr;
        i_req_size   <= sz;
        i_req_signed <= sgn;
        i_req_wdata  <= wd;
        exp_hit      <= hit;
        exp_ale      <= ale;
        exp_load     <= !wr && !ale;
        exp_rdata    <= load_value(addr, sz, sgn);
        in_flight    <= 1'b1;
        if (hold > 0) i_resp_ready <= 1'b0;
        do @(posedge clk); while (!o_req_ready);
        i_req_valid <= 1'b0;
        if (hold > 0) begin
            do @(posedge clk); while (!o_resp_valid);
            repeat (hold) @(posedge clk);
            i_resp_ready <= 1'b1;
        end
        do @(posedge clk); while (!(o_resp_valid && i_resp_ready));
        in_flight <= 1'b0;
        exp_hit   <= 1'b0;
        exp_ale   <= 1'b0;
        exp_load  <= 1'b0;
        if (wr && !ale) store_bytes(addr, sz, wd);
    endtask

    task automatic check_mem_line(input logic [ADDR_W-1:0] addr);
        int                wi;
        logic [DATA_W-1:0] expw;
        for (int w = 0; w < BEATS; w++) begin
            wi   = int'(addr >> 2) + w;
            expw = {sb[4*wi+3], sb[4*wi+2], sb[4*wi+1], sb[4*wi]};
            assert (u_mem.mem[wi] == expw)
                else fail_now($sformatf("** Error: u_mem.mem[%0d] = %h, expected %h",
                                        wi, u_mem.mem[wi], expw));
        end
    endtask

    initial begin
        logic [DATA_W-1:0] r;
        logic [ADDR_W-1:0] a;
        size_t             sz;
        seed         = 60;
        rstn         = 1'b0;
        i_req_valid  = 1'b0;
        i_req_write  = 1'b0;
        i_req_addr   = '0;
        i_req_size   = SZ_WORD;
        i_req_signed = 1'b0;
        i_req_wdata  = '0;
        i_resp_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rstn <= 1'b1;
        for (int i = 0; i < MEM_WORDS; i++) begin
            for (int b = 0; b < 4; b++) sb[4*i+b] = u_mem.mem[i][8*b +: 8];
        end

        access(1'b0, 32'h100, SZ_WORD, 1'b0, '0, 1'b0, 0);   // cold miss
        for (int b = 0; b < 4; b++) begin
            r = $random(seed);
            access(1'b1, 32'h104 + b, SZ_BYTE, 1'b0, r | (b[0] ? 32'h80 : 32'h0), 1'b1, 0);
        end
        r = $random(seed);
        access(1'b1, 32'h108, SZ_HALF, 1'b0, r | 32'h8000, 1'b1, 0);
        access(1'b1, 32'h10c, SZ_WORD, 1'b0, $random(seed), 1'b1, 0);
        access(1'b0, 32'h104, SZ_WORD, 1'b0, '0, 1'b1, 0);
        access(1'b0, 32'h108, SZ_WORD, 1'b0, '0, 1'b1, 0);
        for (int b = 0; b < 4; b++) begin
            access(1'b0, 32'h104 + b, SZ_BYTE, 1'b0, '0, 1'b1, 0);
            access(1'b0, 32'h104 + b, SZ_BYTE, 1'b1, '0, 1'b1, 0);
        end
        for (int h = 0; h < 4; h += 2) begin
            access(1'b0, 32'h108 + h, SZ_HALF, 1'b0, '0, 1'b1, 0);
            access(1'b0, 32'h108 + h, SZ_HALF, 1'b1, '0, 1'b1, 0);
        end

        // three tags into set 1, the dirty first line gets evicted
        access(1'b1, 32'h010, SZ_WORD, 1'b0, $random(seed), 1'b0, 0);
        access(1'b1, 32'h016, SZ_HALF, 1'b0, $random(seed), 1'b1, 0);
        access(1'b0, 32'h110, SZ_WORD, 1'b0, '0, 1'b0, 0);
        access(1'b0, 32'h210, SZ_WORD, 1'b0, '0, 1'b0, 0);
        check_mem_line(32'h010);
        access(1'b0, 32'h010, SZ_WORD, 1'b0, '0, 1'b0, 0);
        access(1'b0, 32'h016, SZ_HALF, 1'b1, '0, 1'b1, 0);

        access(1'b0, 32'h101, SZ_HALF, 1'b0, '0, 1'b0, 0);
        access(1'b1, 32'h102, SZ_WORD, 1'b0, $random(seed), 1'b0, 0);
        access(1'b0, 32'h103, SZ_WORD, 1'b0, '0, 1'b0, 0);
        access(1'b0, 32'h104, SZ_WORD, 1'b0, '0, 1'b1, 6);   // stalled response

        for (int n = 0; n < NUM_RANDOM; n++) begin
            r  = $random(seed);
            sz = size_t'((r[1:0] == 2'd3) ? 2'd2 : r[1:0]);
            a  = {19'd0, r[14:2]};
            if (sz == SZ_WORD) a[1:0] = 2'b00;
            if (sz == SZ_HALF) a[0] = 1'b0;
            access(r[15], a, sz, r[16], $random(seed), 1'b0, 0);
        end

        $display("Test passed");
        $finish;
    end

endmodule

//--- verilog/access_align.sv
`timescale 1ns/100ps

module access_align
    import cache_pkg::*;
(
    input  logic [BYTE_OFF_W-1:0] i_addr_low,
    input  size_t                 i_size,
    input  logic                  i_signed,
    input  logic [DATA_W-1:0]     i_wdata,
    input  logic [DATA_W-1:0]     i_load_word,
    output logic [DATA_W-1:0]     o_store_word,
    output logic [STRB_W-1:0]     o_store_strb,
    output logic [DATA_W-1:0]     o_load_data,
    output logic                  o_ale
);
    logic [DATA_W-1:0] shifted;   // addressed byte moved to lane 0

    assign shifted = i_load_word >> {i_addr_low, 3'b000};

    always_comb begin
        case (i_size)
            SZ_BYTE: begin
                o_store_word = {STRB_W{i_wdata[7:0]}};
                o_store_strb = STRB_W'(1) << i_addr_low;
                o_load_data  = {{(DATA_W-8){i_signed & shifted[7]}}, shifted[7:0]};
                o_ale        = 1'b0;
            end
            SZ_HALF: begin
                o_store_word = {(STRB_W/2){i_wdata[15:0]}};
                o_store_strb = STRB_W'(3) << {i_addr_low[BYTE_OFF_W-1:1], 1'b0};
                o_load_data  = {{(DATA_W-16){i_signed & shifted[15]}}, shifted[15:0]};
                o_ale        = i_addr_low[0];
            end
            default: begin
                o_store_word = i_wdata;
                o_store_strb = '1;
                o_load_data  = i_load_word;
                o_ale        = |i_addr_low;
            end
        endcase
    end

endmodule

//--- verilog/beat_counter.sv
`timescale 1ns/100ps

module beat_counter #(
    parameter int WORD_OFFSET_WIDTH = 2
)(
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         i_start,
    input  logic                         i_step,
    output logic [WORD_OFFSET_WIDTH-1:0] o_beat,
    output logic                         o_last
);
    logic spent;    // final beat taken, burst closed

    assign o_last = &o_beat;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_beat <= '0;
            spent  <= 1'b0;
        end else if (i_start) begin
            o_beat <= '0;
            spent  <= 1'b0;
        end else if (i_step) begin
            o_beat <= o_beat + 1'b1;   // wraps to 0 after the last beat
            spent  <= o_last;
        end
    end

    // no beat beyond the line until the next burst starts
    assert property (@(posedge clk) disable iff (!rstn) spent |-> !i_step || i_start);

endmodule

//--- verilog/cache_ifs.sv
`timescale 1ns/100ps

interface tag_lookup_if #(
    parameter int INDEX_WIDTH = 4,
    parameter int TAG_WIDTH   = 24
);
    logic [INDEX_WIDTH-1:0] index;
    logic [TAG_WIDTH-1:0]   tag;
    logic                   lookup;     // read enable, result one cycle later
    logic                   fill;       // write tag and valid into touch_way
    logic                   dirty_set;
    logic                   dirty_clr;
    logic                   lru_touch;
    logic                   touch_way;
    logic                   hit;
    logic                   hit_way;
    logic                   victim_way;
    logic                   victim_dirty;
    logic [TAG_WIDTH-1:0]   victim_tag;

    modport ctrl (
        output index, tag, lookup, fill, dirty_set, dirty_clr, lru_touch, touch_way,
        input  hit, hit_way, victim_way, victim_dirty, victim_tag
    );
    modport store (
        input  index, tag, lookup, fill, dirty_set, dirty_clr, lru_touch, touch_way,
        output hit, hit_way, victim_way, victim_dirty, victim_tag
    );
endinterface

interface line_data_if #(
    parameter int INDEX_WIDTH       = 4,
    parameter int WORD_OFFSET_WIDTH = 2
);
    logic [INDEX_WIDTH-1:0]       index;
    logic                         way;
    logic                         store_en;
    logic                         fill_en;
    logic                         rd_en;
    logic                         rd_burst;   // read at beat instead of request word
    logic [WORD_OFFSET_WIDTH-1:0] beat;       // burst position from beat_counter
    logic                         last;

    modport ctrl  (output index, way, store_en, fill_en, rd_en, rd_burst);
    modport store (input  index, way, store_en, fill_en, rd_en, rd_burst);
endinterface

//--- verilog/cache_pkg.sv
package cache_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    // byte-in-word address bits
    localparam int BYTE_OFF_W = $clog2(STRB_W);

    // access size of a load or store
    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,
        SZ_HALF = 2'd1,
        SZ_WORD = 2'd2
    } size_t;

endpackage

//--- verilog/data_store.sv
`timescale 1ns/100ps

module data_store
    import cache_pkg::*;
#(
    parameter int INDEX_WIDTH       = 4,
    parameter int WORD_OFFSET_WIDTH = 2
)(
    input  logic                         clk,
    line_data_if.store                   ld,
    input  logic [WORD_OFFSET_WIDTH-1:0] i_beat,
    input  logic [DATA_W-1:0]            i_fill_word,
    input  logic [DATA_W-1:0]            i_store_word,
    input  logic [STRB_W-1:0]            i_store_strb,
    input  logic [WORD_OFFSET_WIDTH-1:0] i_word_sel,
    output logic [DATA_W-1:0]            o_read_word
);
    localparam int WADDR_W = INDEX_WIDTH + WORD_OFFSET_WIDTH;
    localparam int WORDS   = 1 << WADDR_W;

    logic [DATA_W-1:0]  mem  [2][WORDS];
    logic [DATA_W-1:0]  rd_q [2];       // both ways, picked by way afterwards
    logic [WADDR_W-1:0] wr_addr;
    logic [WADDR_W-1:0] rd_addr;

    assign wr_addr = {ld.index, ld.fill_en ? i_beat : i_word_sel};
    assign rd_addr = {ld.index, ld.rd_burst ? i_beat : i_word_sel};

    always_ff @(posedge clk) begin
        if (ld.fill_en) begin
            mem[ld.way][wr_addr] <= i_fill_word;
        end else if (ld.store_en) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (i_store_strb[b]) mem[ld.way][wr_addr][8*b +: 8] <= i_store_word[8*b +: 8];
            end
        end
        if (ld.rd_en) begin
            rd_q[0] <= mem[0][rd_addr];
            rd_q[1] <= mem[1][rd_addr];
        end
    end

    // load word on a hit, victim word during write-back
    assign o_read_word = rd_q[ld.way];

endmodule

//--- verilog/dcache_ctrl.sv
`timescale 1ns/100ps

module dcache_ctrl
    import cache_pkg::*;
#(
    parameter int INDEX_WIDTH       = 4,
    parameter int WORD_OFFSET_WIDTH = 2
)(
    input  logic              clk,
    input  logic              rstn,
    input  logic              i_req_valid,
    output logic              o_req_ready,
    input  logic              i_req_write,
    input  logic [ADDR_W-1:0] i_req_addr,
    input  size_t             i_req_size,
    input  logic              i_req_signed,
    input  logic [DATA_W-1:0] i_req_wdata,
    output logic              o_resp_valid,
    input  logic              i_resp_ready,
    output logic              o_mem_valid,
    input  logic              i_mem_ready,
    output logic              o_mem_write,
    output logic [ADDR_W-1:0] o_mem_addr,
    output logic              o_mem_wvalid,
    input  logic              i_mem_wready,
    input  logic              i_mem_rvalid,
    tag_lookup_if.ctrl        tl,
    line_data_if.ctrl         ld,
    input  logic              i_ale,
    input  logic              i_last,
    output logic              o_beat_start,
    output logic              o_beat_step,
    output logic [ADDR_W-1:0] o_acc_addr,
    output size_t             o_buf_size,
    output logic              o_buf_signed,
    output logic [DATA_W-1:0] o_buf_wdata
);
    localparam int OFF_W = WORD_OFFSET_WIDTH + BYTE_OFF_W;
    localparam int TAG_W = ADDR_W - INDEX_WIDTH - OFF_W;

    typedef enum logic [2:0] {
        IDLE, LOOKUP, RESPOND, WB_ADDR, WB_BEATS, RF_ADDR, RF_BEATS, REPLAY
    } state_t;

    state_t                 state;
    state_t                 next_state;
    logic [ADDR_W-1:0]      addr_q;
    logic                   write_q;
    logic                   wdata_ok;   // data_store output holds the current beat
    logic                   accept;
    logic                   in_burst;
    logic [INDEX_WIDTH-1:0] index;
    logic [TAG_W-1:0]       tag;

    assign o_req_ready = (state == IDLE);
    assign accept      = i_req_valid && o_req_ready;
    assign o_acc_addr  = (state == IDLE) ? i_req_addr : addr_q; // live address only at accept
    assign index       = o_acc_addr[OFF_W +: INDEX_WIDTH];
    assign tag         = o_acc_addr[ADDR_W-1 -: TAG_W];
    assign in_burst    = state inside {WB_ADDR, WB_BEATS, RF_ADDR, RF_BEATS};

    assign tl.index     = index;
    assign tl.tag       = tag;
    assign tl.touch_way = in_burst ? tl.victim_way : tl.hit_way;
    assign ld.index     = index;
    assign ld.way       = in_burst ? tl.victim_way : tl.hit_way;
    assign o_mem_addr   = {(state == WB_ADDR) ? tl.victim_tag : tag, index, {OFF_W{1'b0}}};

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q       <= i_req_addr;
            write_q      <= i_req_write;
            o_buf_size   <= i_req_size;
            o_buf_signed <= i_req_signed;
            o_buf_wdata  <= i_req_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state    <= IDLE;
            wdata_ok <= 1'b0;
        end else begin
            state    <= next_state;
            wdata_ok <= ld.rd_en && ld.rd_burst && !o_beat_step;
        end
    end

    always_comb begin
        next_state   = state;
        o_resp_valid = 1'b0;
        o_mem_valid  = 1'b0;
        o_mem_write  = 1'b0;
        o_mem_wvalid = 1'b0;
        o_beat_start = 1'b0;
        o_beat_step  = 1'b0;
        tl.lookup    = 1'b0;
        tl.fill      = 1'b0;
        tl.dirty_set = 1'b0;
        tl.dirty_clr = 1'b0;
        tl.lru_touch = 1'b0;
        ld.store_en  = 1'b0;
        ld.fill_en   = 1'b0;
        ld.rd_en     = 1'b0;
        ld.rd_burst  = 1'b0;
        case (state)
            IDLE: begin
                tl.lookup = accept;
                ld.rd_en  = accept;
                if (accept) next_state = LOOKUP;
            end
            LOOKUP: begin
                if (i_ale) begin
                    next_state = RESPOND;   // answered without cache side effects
                end else if (tl.hit) begin
                    tl.lru_touch = 1'b1;
                    ld.store_en  = write_q;
                    tl.dirty_set = write_q;
                    next_state   = RESPOND;
                end else begin
                    o_beat_start = 1'b1;
                    next_state   = tl.victim_dirty ? WB_ADDR : RF_ADDR;
                end
            end
            RESPOND: begin
                o_resp_valid = 1'b1;
                if (i_resp_ready) next_state = IDLE;
            end
            WB_ADDR: begin
                o_mem_valid = 1'b1;
                o_mem_write = 1'b1;
                ld.rd_en    = 1'b1;   // prefetch beat 0 while the address waits
                ld.rd_burst = 1'b1;
                if (i_mem_ready) next_state = WB_BEATS;
            end
            WB_BEATS: begin
                ld.rd_en     = 1'b1;
                ld.rd_burst  = 1'b1;
                o_mem_wvalid = wdata_ok;
                if (wdata_ok && i_mem_wready) begin
                    o_beat_step = 1'b1;
                    if (i_last) begin
                        o_beat_start = 1'b1;
                        next_state   = RF_ADDR;
                    end
                end
            end
            RF_ADDR: begin
                o_mem_valid = 1'b1;
                if (i_mem_ready) next_state = RF_BEATS;
            end
            RF_BEATS: begin
                if (i_mem_rvalid) begin
                    ld.fill_en  = 1'b1;
                    o_beat_step = 1'b1;
                    if (i_last) begin
                        tl.fill      = 1'b1;
                        tl.dirty_clr = 1'b1;
                        next_state   = REPLAY;
                    end
                end
            end
            REPLAY: begin
                tl.lookup  = 1'b1;
                ld.rd_en   = 1'b1;
                next_state = LOOKUP;
            end
            default: next_state = IDLE;
        endcase
    end

    // address phase holds until the memory takes it
    assert property (@(posedge clk) disable iff (!rstn)
        o_mem_valid && !i_mem_ready |=> o_mem_valid && $stable(o_mem_addr) && $stable(o_mem_write));

endmodule

//--- verilog/dcache_top.sv
`timescale 1ns/100ps

module dcache_top
    import cache_pkg::*;
#(
    parameter int INDEX_WIDTH       = 4,
    parameter int WORD_OFFSET_WIDTH = 2
)(
    input  logic              clk,
    input  logic              rstn,
    input  logic              i_req_valid,
    output logic              o_req_ready,
    input  logic              i_req_write,
    input  logic [ADDR_W-1:0] i_req_addr,
    input  size_t             i_req_size,
    input  logic              i_req_signed,
    input  logic [DATA_W-1:0] i_req_wdata,
    output logic              o_resp_valid,
    input  logic              i_resp_ready,
    output logic [DATA_W-1:0] o_resp_rdata,
    output logic              o_resp_ale,
    output logic              o_mem_valid,
    input  logic              i_mem_ready,
    output logic              o_mem_write,
    output logic [ADDR_W-1:0] o_mem_addr,
    input  logic              i_mem_rvalid,
    input  logic [DATA_W-1:0] i_mem_rdata,
    output logic              o_mem_wvalid,
    input  logic              i_mem_wready,
    output logic [DATA_W-1:0] o_mem_wdata
);
    localparam int TAG_WIDTH = ADDR_W - INDEX_WIDTH - WORD_OFFSET_WIDTH - BYTE_OFF_W;

    logic [ADDR_W-1:0] acc_addr;
    size_t             buf_size;
    logic              buf_signed;
    logic [DATA_W-1:0] buf_wdata;
    logic [DATA_W-1:0] store_word;
    logic [STRB_W-1:0] store_strb;
    logic              beat_start;
    logic              beat_step;

    tag_lookup_if #(.INDEX_WIDTH(INDEX_WIDTH), .TAG_WIDTH(TAG_WIDTH)) u_tl_if ();
    line_data_if #(.INDEX_WIDTH(INDEX_WIDTH), .WORD_OFFSET_WIDTH(WORD_OFFSET_WIDTH)) u_ld_if ();

    dcache_ctrl #(
        .INDEX_WIDTH       (INDEX_WIDTH),
        .WORD_OFFSET_WIDTH (WORD_OFFSET_WIDTH)
    ) u_ctrl (
        .clk          (clk),
        .rstn         (rstn),
        .i_req_valid  (i_req_valid),
        .o_req_ready  (o_req_ready),
        .i_req_write  (i_req_write),
        .i_req_addr   (i_req_addr),
        .i_req_size   (i_req_size),
        .i_req_signed (i_req_signed),
        .i_req_wdata  (i_req_wdata),
        .o_resp_valid (o_resp_valid),
        .i_resp_ready (i_resp_ready),
        .o_mem_valid  (o_mem_valid),
        .i_mem_ready  (i_mem_ready),
        .o_mem_write  (o_mem_write),
        .o_mem_addr   (o_mem_addr),
        .o_mem_wvalid (o_mem_wvalid),
        .i_mem_wready (i_mem_wready),
        .i_mem_rvalid (i_mem_rvalid),
        .tl           (u_tl_if.ctrl),
        .ld           (u_ld_if.ctrl),
        .i_ale        (o_resp_ale),
        .i_last       (u_ld_if.last),
        .o_beat_start (beat_start),
        .o_beat_step  (beat_step),
        .o_acc_addr   (acc_addr),
        .o_buf_size   (buf_size),
        .o_buf_signed (buf_signed),
        .o_buf_wdata  (buf_wdata)
    );

    beat_counter #(.WORD_OFFSET_WIDTH(WORD_OFFSET_WIDTH)) u_beat_counter (
        .clk     (clk),
        .rstn    (rstn),
        .i_start (beat_start),
        .i_step  (beat_step),
        .o_beat  (u_ld_if.beat),
        .o_last  (u_ld_if.last)
    );

    tag_store #(
        .INDEX_WIDTH       (INDEX_WIDTH),
        .WORD_OFFSET_WIDTH (WORD_OFFSET_WIDTH)
    ) u_tag_store (
        .clk  (clk),
        .rstn (rstn),
        .tl   (u_tl_if.store)
    );

    data_store #(
        .INDEX_WIDTH       (INDEX_WIDTH),
        .WORD_OFFSET_WIDTH (WORD_OFFSET_WIDTH)
    ) u_data_store (
        .clk          (clk),
        .ld           (u_ld_if.store),
        .i_beat       (u_ld_if.beat),
        .i_fill_word  (i_mem_rdata),
        .i_store_word (store_word),
        .i_store_strb (store_strb),
        .i_word_sel   (acc_addr[BYTE_OFF_W +: WORD_OFFSET_WIDTH]),
        .o_read_word  (o_mem_wdata)
    );

    access_align u_access_align (
        .i_addr_low   (acc_addr[BYTE_OFF_W-1:0]),
        .i_size       (buf_size),
        .i_signed     (buf_signed),
        .i_wdata      (buf_wdata),
        .i_load_word  (o_mem_wdata),
        .o_store_word (store_word),
        .o_store_strb (store_strb),
        .o_load_data  (o_resp_rdata),
        .o_ale        (o_resp_ale)
    );

endmodule

//--- verilog/tag_store.sv
`timescale 1ns/100ps

module tag_store
    import cache_pkg::*;
#(
    parameter int INDEX_WIDTH       = 4,
    parameter int WORD_OFFSET_WIDTH = 2
)(
    input  logic        clk,
    input  logic        rstn,
    tag_lookup_if.store tl
);
    localparam int SETS  = 1 << INDEX_WIDTH;
    localparam int TAG_W = ADDR_W - INDEX_WIDTH - WORD_OFFSET_WIDTH - BYTE_OFF_W;

    logic [TAG_W-1:0]       tag_q   [2][SETS];
    logic [SETS-1:0]        valid_q [2];
    logic [SETS-1:0]        dirty_q [2];
    logic [SETS-1:0]        lru_q;      // way to replace next
    logic [INDEX_WIDTH-1:0] idx_q;      // set of the last lookup
    logic [1:0]             way_hit;

    assign way_hit[0] = valid_q[0][tl.index] && (tag_q[0][tl.index] == tl.tag);
    assign way_hit[1] = valid_q[1][tl.index] && (tag_q[1][tl.index] == tl.tag);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int w = 0; w < 2; w++) begin
                valid_q[w] <= '0;
                dirty_q[w] <= '0;
                for (int s = 0; s < SETS; s++) begin
                    tag_q[w][s] <= '0;
                end
            end
            lru_q      <= '0;
            idx_q      <= '0;
            tl.hit     <= 1'b0;
            tl.hit_way <= 1'b0;
        end else begin
            if (tl.lookup) begin
                idx_q      <= tl.index;
                tl.hit     <= |way_hit;
                tl.hit_way <= way_hit[1];
            end
            if (tl.fill) begin
                tag_q[tl.touch_way][tl.index]   <= tl.tag;
                valid_q[tl.touch_way][tl.index] <= 1'b1;
            end
            if (tl.dirty_set) begin
                dirty_q[tl.touch_way][tl.index] <= 1'b1;
            end else if (tl.dirty_clr) begin
                dirty_q[tl.touch_way][tl.index] <= 1'b0;
            end
            if (tl.lru_touch) lru_q[tl.index] <= ~tl.touch_way;
        end
    end

    // an empty way wins over the LRU choice
    always_comb begin
        if (!valid_q[0][idx_q])      tl.victim_way = 1'b0;
        else if (!valid_q[1][idx_q]) tl.victim_way = 1'b1;
        else                         tl.victim_way = lru_q[idx_q];
    end

    assign tl.victim_dirty = valid_q[tl.victim_way][idx_q] && dirty_q[tl.victim_way][idx_q];
    assign tl.victim_tag   = tag_q[tl.victim_way][idx_q];

    // refill never duplicates a line, so one way at most matches
    assert property (@(posedge clk) disable iff (!rstn) tl.lookup |-> !(&way_hit));

endmodule
